/* mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	////////////////////
	// Opcodes
	////////////////////

	// All R-type share opcode zero and use funct to pick the operation
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	// Core stops fetching on this one
	localparam logic [5:0] opHalt = 6'h3f;

	// R-type function codes
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSll = 6'h00;

	////////////////////
	// Field positions
	////////////////////

	localparam int opHi = 31;
	localparam int opLo = 26;
	localparam int rsHi = 25;
	localparam int rsLo = 21;
	localparam int rtHi = 20;
	localparam int rtLo = 16;
	localparam int rdHi = 15;
	localparam int rdLo = 11;
	localparam int shamtHi = 10;
	localparam int shamtLo = 6;
	localparam int fnHi = 5;
	localparam int fnLo = 0;
	// 16-bit immediate of I-type
	localparam int immHi = 15;
	localparam int immLo = 0;

	// ALU operations
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluSlt = 4'd4,
		aluSll = 4'd5
	} aluOpT;

endpackage

`default_nettype wire

/* mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

	////////////////////
	// FSM states
	////////////////////

	typedef enum logic [3:0] {
		fetch = 4'd0,
		decode = 4'd1,
		memAddr = 4'd2,
		memRead = 4'd3,
		memWriteback = 4'd4,
		memWrite = 4'd5,
		execute = 4'd6,
		aluWriteback = 4'd7,
		branch = 4'd8,
		// Terminal, left only by reset
		halt = 4'd9
	} ctrlStateT;

	// ALU operand A sources
	localparam logic [1:0] srcAPc = 2'd0;
	localparam logic [1:0] srcARegA = 2'd1;
	// Shift source for sll
	localparam logic [1:0] srcARegB = 2'd2;

	// ALU operand B sources
	localparam logic [1:0] srcBRegB = 2'd0;
	localparam logic [1:0] srcBFour = 2'd1;
	localparam logic [1:0] srcBImm = 2'd2;
	localparam logic [1:0] srcBShamt = 2'd3;

	// Datapath control word
	typedef struct packed {
		logic pcWrite;
		logic branch;
		logic iOrD;
		logic irWrite;
		logic regDst;
		logic memToReg;
		logic regWrite;
		logic memWrite;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		mipsIsaPkg::aluOpT aluOp;
	} ctrlWordT;

endpackage

`default_nettype wire

/* mipsAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsAlu (
	input wire [31:0] srcA,
	input wire [31:0] srcB,
	input wire mipsIsaPkg::aluOpT aluOp,
	output logic [31:0] result,
	output logic zero
);

	// Signed compare for slt
	logic lessThan;

	assign lessThan = $signed(srcA) < $signed(srcB);

	////////////////////
	// Operation select
	////////////////////

	always_comb begin
		case (aluOp)
			mipsIsaPkg::aluAdd: begin
				result = srcA + srcB;
			end
			mipsIsaPkg::aluSub: begin
				result = srcA - srcB;
			end
			mipsIsaPkg::aluAnd: begin
				result = srcA & srcB;
			end
			mipsIsaPkg::aluOr: begin
				result = srcA | srcB;
			end
			mipsIsaPkg::aluSlt: begin
				result = {31'd0, lessThan};
			end
			mipsIsaPkg::aluSll: begin
				// Only the low five bits matter as shift amount
				result = srcA << srcB[4:0];
			end
			default: begin
				result = srcA + srcB;
			end
		endcase
	end

	// Equality test for beq comes from sub
	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

/* mipsRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile (
	input wire clk,
	input wire rstN,
	input wire [4:0] rdAddrA,
	input wire [4:0] rdAddrB,
	input wire [4:0] wrAddr,
	input wire [31:0] wrData,
	input wire wrEna,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB
);

	logic [31:0] regs [32];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wrEna && (wrAddr != 5'd0)) begin
			// r0 stays hardwired to zero
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads
	assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

`default_nettype wire

/* mipsPcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsPcUnit #(
	parameter logic [31:0] resetPc = 32'h0,
	parameter int countWidth = 32
) (
	input wire clk,
	input wire rstN,
	input wire mipsCtrlPkg::ctrlWordT ctrl,
	input wire [31:0] nextPc,
	input wire zero,
	output logic [31:0] pc,
	output logic [countWidth-1:0] instrCount
);

	logic pcEna;
	logic retire;

	// Taken branch or fetch increment
	assign pcEna = ctrl.pcWrite | (ctrl.branch & zero);

	// Every non-halt instruction ends on one of these
	assign retire = ctrl.regWrite | ctrl.memWrite | ctrl.branch;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			instrCount <= '0;
		end else begin
			if (pcEna) begin
				pc <= nextPc;
			end
			if (retire) begin
				instrCount <= instrCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* mipsController.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsController (
	input wire clk,
	input wire rstN,
	input wire [5:0] opcode,
	input wire [5:0] funct,
	output mipsCtrlPkg::ctrlWordT ctrl,
	output logic halted
);

	mipsCtrlPkg::ctrlStateT state;
	mipsCtrlPkg::ctrlStateT nextState;
	mipsIsaPkg::aluOpT fnOp;
	logic isRtype;
	logic isSll;

	assign isRtype = (opcode == mipsIsaPkg::opRtype);
	assign isSll = isRtype && (funct == mipsIsaPkg::fnSll);

	////////////////////
	// State register
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= mipsCtrlPkg::fetch;
		end else begin
			state <= nextState;
		end
	end

	// Funct to ALU op
	always_comb begin
		case (funct)
			mipsIsaPkg::fnAdd: fnOp = mipsIsaPkg::aluAdd;
			mipsIsaPkg::fnSub: fnOp = mipsIsaPkg::aluSub;
			mipsIsaPkg::fnAnd: fnOp = mipsIsaPkg::aluAnd;
			mipsIsaPkg::fnOr: fnOp = mipsIsaPkg::aluOr;
			mipsIsaPkg::fnSlt: fnOp = mipsIsaPkg::aluSlt;
			mipsIsaPkg::fnSll: fnOp = mipsIsaPkg::aluSll;
			default: fnOp = mipsIsaPkg::aluAdd;
		endcase
	end

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		nextState = state;
		case (state)
			mipsCtrlPkg::fetch: nextState = mipsCtrlPkg::decode;
			mipsCtrlPkg::decode: begin
				case (opcode)
					mipsIsaPkg::opLw, mipsIsaPkg::opSw: nextState = mipsCtrlPkg::memAddr;
					mipsIsaPkg::opRtype, mipsIsaPkg::opAddi: nextState = mipsCtrlPkg::execute;
					mipsIsaPkg::opBeq: nextState = mipsCtrlPkg::branch;
					// halt and anything unknown
					default: nextState = mipsCtrlPkg::halt;
				endcase
			end
			mipsCtrlPkg::memAddr: begin
				if (opcode == mipsIsaPkg::opLw) begin
					nextState = mipsCtrlPkg::memRead;
				end else begin
					nextState = mipsCtrlPkg::memWrite;
				end
			end
			mipsCtrlPkg::memRead: nextState = mipsCtrlPkg::memWriteback;
			mipsCtrlPkg::execute: nextState = mipsCtrlPkg::aluWriteback;
			mipsCtrlPkg::halt: nextState = mipsCtrlPkg::halt;
			// Final cycles go back to fetch
			default: nextState = mipsCtrlPkg::fetch;
		endcase
	end

	////////////////////
	// Control word
	////////////////////

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = mipsIsaPkg::aluAdd;
		case (state)
			mipsCtrlPkg::fetch: begin
				// IR <= mem[pc], pc <= pc + 4
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
				ctrl.aluSrcA = mipsCtrlPkg::srcAPc;
				ctrl.aluSrcB = mipsCtrlPkg::srcBFour;
			end
			mipsCtrlPkg::decode: begin
				// Branch target into ALUOut ahead of time
				ctrl.aluSrcA = mipsCtrlPkg::srcAPc;
				ctrl.aluSrcB = mipsCtrlPkg::srcBImm;
			end
			mipsCtrlPkg::memAddr: begin
				ctrl.aluSrcA = mipsCtrlPkg::srcARegA;
				ctrl.aluSrcB = mipsCtrlPkg::srcBImm;
			end
			mipsCtrlPkg::memRead: begin
				ctrl.iOrD = 1'b1;
			end
			mipsCtrlPkg::memWriteback: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsCtrlPkg::memWrite: begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsCtrlPkg::execute: begin
				// sll shifts rt, everything else starts from rs
				ctrl.aluSrcA = isSll ? mipsCtrlPkg::srcARegB : mipsCtrlPkg::srcARegA;
				if (!isRtype) begin
					ctrl.aluSrcB = mipsCtrlPkg::srcBImm;
				end else if (isSll) begin
					ctrl.aluSrcB = mipsCtrlPkg::srcBShamt;
				end else begin
					ctrl.aluSrcB = mipsCtrlPkg::srcBRegB;
				end
				ctrl.aluOp = isRtype ? fnOp : mipsIsaPkg::aluAdd;
			end
			mipsCtrlPkg::aluWriteback: begin
				// rd for R-type, rt for addi
				ctrl.regDst = isRtype;
				ctrl.regWrite = 1'b1;
			end
			mipsCtrlPkg::branch: begin
				ctrl.aluSrcA = mipsCtrlPkg::srcARegA;
				ctrl.aluSrcB = mipsCtrlPkg::srcBRegB;
				ctrl.aluOp = mipsIsaPkg::aluSub;
				ctrl.branch = 1'b1;
			end
			default: begin
				// halt drives nothing
			end
		endcase
	end

	assign halted = (state == mipsCtrlPkg::halt);

endmodule

`default_nettype wire

/* mipsDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsDatapath (
	input wire clk,
	input wire rstN,
	input wire mipsCtrlPkg::ctrlWordT ctrl,
	input wire [31:0] pc,
	input wire [31:0] memRdData,
	input wire [31:0] aluResult,
	input wire [31:0] rdDataA,
	input wire [31:0] rdDataB,
	output logic [31:0] memAddr,
	output logic [31:0] memWrData,
	output logic [31:0] srcA,
	output logic [31:0] srcB,
	output logic [31:0] nextPc,
	output logic [5:0] opcode,
	output logic [5:0] funct,
	output logic [4:0] rdAddrA,
	output logic [4:0] rdAddrB,
	output logic [4:0] wrAddr,
	output logic [31:0] wrData
);

	logic [31:0] instr;
	logic [31:0] dataReg;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] aluOut;
	logic [31:0] signImm;
	logic [31:0] immOperand;
	logic [31:0] padShamt;

	////////////////////
	// Holding registers
	////////////////////

	// Instruction register, loaded in fetch
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instr <= 32'd0;
		end else if (ctrl.irWrite) begin
			instr <= memRdData;
		end
	end

	// Reloaded every cycle
	always_ff @(posedge clk) begin
		dataReg <= memRdData;
		regA <= rdDataA;
		regB <= rdDataB;
		aluOut <= aluResult;
	end

	// Instruction fields
	assign opcode = instr[mipsIsaPkg::opHi:mipsIsaPkg::opLo];
	assign funct = instr[mipsIsaPkg::fnHi:mipsIsaPkg::fnLo];
	assign rdAddrA = instr[mipsIsaPkg::rsHi:mipsIsaPkg::rsLo];
	assign rdAddrB = instr[mipsIsaPkg::rtHi:mipsIsaPkg::rtLo];

	// Immediate and shift amount
	assign signImm = {{16{instr[mipsIsaPkg::immHi]}},
		instr[mipsIsaPkg::immHi:mipsIsaPkg::immLo]};
	assign padShamt = {27'd0, instr[mipsIsaPkg::shamtHi:mipsIsaPkg::shamtLo]};

	// Word offset when added to pc
	assign immOperand = (ctrl.aluSrcA == mipsCtrlPkg::srcAPc) ?
		{signImm[29:0], 2'b00} : signImm;

	////////////////////
	// Operand muxes
	////////////////////

	always_comb begin
		case (ctrl.aluSrcA)
			mipsCtrlPkg::srcARegA: srcA = regA;
			mipsCtrlPkg::srcARegB: srcA = regB;
			default: srcA = pc;
		endcase
	end

	always_comb begin
		case (ctrl.aluSrcB)
			mipsCtrlPkg::srcBFour: srcB = 32'd4;
			mipsCtrlPkg::srcBImm: srcB = immOperand;
			mipsCtrlPkg::srcBShamt: srcB = padShamt;
			default: srcB = regB;
		endcase
	end

	// Register write back
	assign wrAddr = ctrl.regDst ? instr[mipsIsaPkg::rdHi:mipsIsaPkg::rdLo] :
		instr[mipsIsaPkg::rtHi:mipsIsaPkg::rtLo];
	assign wrData = ctrl.memToReg ? dataReg : aluOut;

	// Memory side
	assign memAddr = ctrl.iOrD ? aluOut : pc;
	assign memWrData = regB;

	// Branch uses target saved in decode
	assign nextPc = ctrl.branch ? aluOut : aluResult;

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
	parameter logic [31:0] resetPc = 32'h0,
	parameter int countWidth = 32
) (
	input wire clk,
	input wire rstN,
	input wire [31:0] memRdData,
	output logic [31:0] memAddr,
	output logic memWrEna,
	output logic [31:0] memWrData,
	output logic halted,
	output logic [countWidth-1:0] instrCount
);

	mipsCtrlPkg::ctrlWordT ctrl;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic zero;
	logic [4:0] rdAddrA;
	logic [4:0] rdAddrB;
	logic [4:0] wrAddr;
	logic [31:0] wrData;
	logic [31:0] rdDataA;
	logic [31:0] rdDataB;

	// Write strobe straight from the control word
	assign memWrEna = ctrl.memWrite;

	////////////////////
	// Control
	////////////////////

	mipsController ctrlFsm (
		.clk(clk),
		.rstN(rstN),
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl),
		.halted(halted)
	);

	////////////////////
	// Datapath
	////////////////////

	mipsDatapath datapath (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.pc(pc),
		.memRdData(memRdData),
		.aluResult(aluResult),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.srcA(srcA),
		.srcB(srcB),
		.nextPc(nextPc),
		.opcode(opcode),
		.funct(funct),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	mipsRegFile regFile (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrEna(ctrl.regWrite),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	mipsAlu alu (
		.srcA(srcA),
		.srcB(srcB),
		.aluOp(ctrl.aluOp),
		.result(aluResult),
		.zero(zero)
	);

	// PC and retire counter
	mipsPcUnit #(
		.resetPc(resetPc),
		.countWidth(countWidth)
	) pcUnit (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.nextPc(nextPc),
		.zero(zero),
		.pc(pc),
		.instrCount(instrCount)
	);

endmodule

`default_nettype wire

/* mipsCore_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore_chk (
	input wire clk,
	input wire rstN,
	input wire [31:0] memAddr,
	input wire memWrEna,
	input wire halted
);

	// Count of failed assertions
	int assertFails = 0;

	////////////////////
	// Bus rules
	////////////////////

	// No stores once the core has stopped
	noWriteWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
		!(memWrEna && halted))
		else begin
			$error("memWrEna high while halted");
			assertFails = assertFails + 1;
		end

	// Word stores only
	alignedWrite: assert property (@(posedge clk) disable iff (!rstN)
		memWrEna |-> (memAddr[1:0] == 2'b00))
		else begin
			$error("memWrEna high with unaligned memAddr %h", memAddr);
			assertFails = assertFails + 1;
		end

	// Halt is sticky until reset
	haltSticky: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted)
		else begin
			$error("halted dropped without reset");
			assertFails = assertFails + 1;
		end

endmodule

bind mipsCore mipsCore_chk chkI (
	.clk(clk),
	.rstN(rstN),
	.memAddr(memAddr),
	.memWrEna(memWrEna),
	.halted(halted)
);

`default_nettype wire

/* mipsCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore_tb;

	localparam logic [31:0] resetPc = 32'h0;
	localparam int countWidth = 16;
	// 52 random, 7 register stores, 1 halt
	localparam int bodyLen = 52;
	localparam int progLen = 60;
	localparam int numTests = 3;
	localparam int memWords = 256;
	// Data region in words, above the program
	localparam int dataBase = 128;
	localparam int dataWords = 64;
	// Six cycles per instruction, longer than lw
	// Margin for resets and the halt watch
	localparam int cycleLimit = 6 * progLen * numTests + 200;

	logic clk;
	logic rstN;
	logic [31:0] memRdData;
	logic [31:0] memAddr;
	logic memWrEna;
	logic [31:0] memWrData;
	logic halted;
	logic [countWidth-1:0] instrCount;

	logic [31:0] mem [memWords];
	// Model copy of the memory image
	logic [31:0] image [memWords];
	logic [31:0] expAddrQ [$];
	logic [31:0] expDataQ [$];
	logic [31:0] dutAddrQ [$];
	logic [31:0] dutDataQ [$];
	int expCount;
	int haltedWrites;
	int errorCount = 0;
	int checkCount = 0;
	int cycles = 0;

	mipsCore #(
		.resetPc(resetPc),
		.countWidth(countWidth)
	) mipsCore_i (
		.clk(clk),
		.rstN(rstN),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrEna(memWrEna),
		.memWrData(memWrData),
		.halted(halted),
		.instrCount(instrCount)
	);

	always #10 clk = ~clk;

	////////////////////
	// Memory and timeout
	////////////////////

	// Read before write
	// A store shows up from the next cycle on
	always @(negedge clk) begin
		memRdData = mem[memAddr[9:2]];
		if (memWrEna) begin
			mem[memAddr[9:2]] = memWrData;
			dutAddrQ.push_back(memAddr);
			dutDataQ.push_back(memWrData);
			if (halted) begin
				haltedWrites = haltedWrites + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the core did not reach halt", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount = checkCount + 1;
		if (got !== exp) begin
			errorCount = errorCount + 1;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////
	// Program builder
	////////////////////

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] fn);
		return {mipsIsaPkg::opRtype, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Few registers so results feed each other
	function automatic logic [4:0] randReg();
		return 5'($urandom_range(7, 0));
	endfunction

	// kinds 7 is ALU only, 9 adds lw and sw, 10 adds beq
	task automatic genProgram(input int kinds);
		int pick;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] dataImm;
		for (int i = 0; i < memWords; i++) begin
			mem[i] = 32'(i) * 32'h9e3779b9 + 32'h00006a09;
		end
		for (int i = 0; i < bodyLen; i++) begin
			pick = $urandom_range(kinds - 1, 0);
			rs = randReg();
			rt = randReg();
			rd = randReg();
			// Immediate is the address with base r0
			dataImm = 16'(4 * (dataBase + $urandom_range(dataWords - 1, 0)));
			case (pick)
				0: mem[i] = encodeR(rs, rt, rd, 5'd0, mipsIsaPkg::fnAdd);
				1: mem[i] = encodeR(rs, rt, rd, 5'd0, mipsIsaPkg::fnSub);
				2: mem[i] = encodeR(rs, rt, rd, 5'd0, mipsIsaPkg::fnAnd);
				3: mem[i] = encodeR(rs, rt, rd, 5'd0, mipsIsaPkg::fnOr);
				4: mem[i] = encodeR(rs, rt, rd, 5'd0, mipsIsaPkg::fnSlt);
				5: mem[i] = encodeR(5'd0, rt, rd, 5'($urandom_range(7, 0)), mipsIsaPkg::fnSll);
				6: mem[i] = encodeI(mipsIsaPkg::opAddi, rs, rt,
					16'($urandom_range(31, 0)) - 16'd16);
				7: mem[i] = encodeI(mipsIsaPkg::opLw, 5'd0, rt, dataImm);
				8: mem[i] = encodeI(mipsIsaPkg::opSw, 5'd0, rt, dataImm);
				default: begin
					// Half the branches compare a register with itself
					if ($urandom_range(1, 0) == 1) begin
						rt = rs;
					end
					mem[i] = encodeI(mipsIsaPkg::opBeq, rs, rt, 16'($urandom_range(3, 0)));
				end
			endcase
		end
		// Dump every register in use and stop
		for (int r = 1; r < 8; r++) begin
			mem[bodyLen + r - 1] = encodeI(mipsIsaPkg::opSw, 5'd0, 5'(r), 16'(4 * (dataBase + r)));
		end
		mem[progLen - 1] = encodeI(mipsIsaPkg::opHalt, 5'd0, 5'd0, 16'd0);
		for (int i = 0; i < memWords; i++) begin
			image[i] = mem[i];
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [31:0] addr;
		logic [4:0] rt;
		logic [4:0] rd;
		logic done;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'd0;
		end
		pc = resetPc;
		done = 1'b0;
		expCount = 0;
		expAddrQ.delete();
		expDataQ.delete();
		while (!done) begin
			ins = image[pc[9:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			rt = ins[20:16];
			rd = ins[15:11];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			pc = pc + 32'd4;
			case (ins[31:26])
				mipsIsaPkg::opRtype: begin
					case (ins[5:0])
						mipsIsaPkg::fnAdd: res = a + b;
						mipsIsaPkg::fnSub: res = a - b;
						mipsIsaPkg::fnAnd: res = a & b;
						mipsIsaPkg::fnOr: res = a | b;
						mipsIsaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						mipsIsaPkg::fnSll: res = b << ins[10:6];
						default: res = 32'd0;
					endcase
					regs[rd] = res;
				end
				mipsIsaPkg::opAddi: regs[rt] = a + imm;
				mipsIsaPkg::opLw: regs[rt] = image[addr[9:2]];
				mipsIsaPkg::opSw: begin
					image[addr[9:2]] = b;
					expAddrQ.push_back(addr);
					expDataQ.push_back(b);
				end
				mipsIsaPkg::opBeq: begin
					// Target relative to the next instruction
					if (a == b) begin
						pc = pc + (imm << 2);
					end
				end
				default: done = 1'b1;
			endcase
			// r0 stays zero
			regs[0] = 32'd0;
			if (!done) begin
				expCount = expCount + 1;
			end
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	task automatic runTest(input string name, input int kinds);
		int startErrors;
		startErrors = errorCount;
		@(negedge clk);
		rstN = 1'b0;
		genProgram(kinds);
		runModel();
		dutAddrQ.delete();
		dutDataQ.delete();
		haltedWrites = 0;
		repeat (3) @(negedge clk);
		// State right out of reset
		checkEq("memAddr", memAddr, resetPc);
		checkEq("memWrEna", 32'(memWrEna), 32'd0);
		checkEq("halted", 32'(halted), 32'd0);
		checkEq("instrCount", 32'(instrCount), 32'd0);
		rstN = 1'b1;
		// Run until the core stops
		while (!halted) begin
			@(negedge clk);
		end
		repeat (8) begin
			@(negedge clk);
			checkEq("halted", 32'(halted), 32'd1);
		end
		checkEq("writes after halt", haltedWrites, 32'd0);
		checkEq("instrCount", 32'(instrCount), expCount);
		checkEq("store count", dutAddrQ.size(), expAddrQ.size());
		for (int i = 0; i < expAddrQ.size() && i < dutAddrQ.size(); i++) begin
			checkEq($sformatf("memAddr of store %0d", i), dutAddrQ[i], expAddrQ[i]);
			checkEq($sformatf("memWrData of store %0d", i), dutDataQ[i], expDataQ[i]);
		end
		$display("%s test finished: %0d instructions, %0d stores, %0d mismatches",
			name, expCount, expAddrQ.size(), errorCount - startErrors);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		memRdData = 32'd0;
		haltedWrites = 0;
		void'($urandom(32'h6207));
		runTest("alu", 7);
		runTest("load/store", 9);
		runTest("branch", 10);
		checkEq("assertion failures", mipsCore_i.chkI.assertFails, 32'd0);
		$display("Checks run: %0d, failed: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
mipsIsaPkg.sv
mipsCtrlPkg.sv
mipsAlu.sv
mipsRegFile.sv
mipsPcUnit.sv
mipsController.sv
mipsDatapath.sv
mipsCore.sv
mipsCore_chk.sv
mipsCore_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mipsCore_tb -f compile.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Test OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
